//--- logic/core_pkg.sv
// ####################################################################
// Core package: cache port structs, fetch and redirect types, retire
// trace record and the opcode constants of the supported subset
// ####################################################################

package core_pkg;

  // Cause of an instruction fetch
  typedef enum logic [1:0] {
    IF_SEQ,
    IF_BRANCH,
    IF_TRAP,
    IF_RESET
  } if_reason_e;

  typedef enum logic {
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef struct packed {
    logic        req_valid;
    logic [63:0] req_pc;
    if_reason_e  req_reason;
  } icache_h2d_t;

  typedef struct packed {
    logic        resp_valid;
    logic [31:0] resp_instr;
  } icache_d2h_t;

  typedef struct packed {
    logic        req_valid;
    logic [63:0] req_address;
    logic [63:0] req_value;
    mem_op_e     req_op;
  } dcache_h2d_t;

  typedef struct packed {
    logic        req_ready;
    logic        resp_valid;
    logic [63:0] resp_value;
  } dcache_d2h_t;

  // Frontend to backend
  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [31:0] instr;
  } fetch_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    if_reason_e  reason;
  } redirect_t;

  // One retired instruction
  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [31:0] instr_word;
    logic        gpr_written;
    logic [4:0]  gpr;
    logic [63:0] gpr_data;
    logic        illegal;
    logic [31:0] reserved;
  } instr_trace_t;

  // Major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 / funct7 fields
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_DW  = 3'b011;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

//--- logic/core_regfile.sv
// ####################################################################
// Integer register file, 32 x 64 bits with x0 hardwired to zero
// ####################################################################

`timescale 1ns/1ps

module core_regfile (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [63:0] rdata_a_o,
  output logic [63:0] rdata_b_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [63:0] wdata_i
);

  // No storage behind x0
  logic [63:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && waddr_i != 5'd0)
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == 5'd0) ? 64'd0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? 64'd0 : regs_q[raddr_b_i];

endmodule

//--- logic/core_frontend.sv
// ####################################################################
// Core frontend: fetch PC, instruction cache requests, redirects
// and a one-entry instruction buffer towards the backend
// ####################################################################

`timescale 1ns/1ps

module core_frontend #(
  parameter logic [63:0] ResetPc = 64'h0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  output core_pkg::icache_h2d_t icache_h2d_o,
  input  core_pkg::icache_d2h_t icache_d2h_i,
  input  core_pkg::redirect_t   redirect_i,
  output core_pkg::fetch_t      fetch_o,
  input  logic                  fetch_ready_i
);
  import core_pkg::*;

  logic [63:0] pc_q;
  if_reason_e  reason_q;
  logic        outstanding_q;
  logic        stale_q;
  logic        req_valid_q;
  logic [63:0] req_pc_q;
  if_reason_e  req_reason_q;
  logic        buf_valid_q;
  logic [63:0] buf_pc_q;
  logic [31:0] buf_instr_q;

  logic        resp_keep;
  logic        buf_taken;
  logic        issue;
  logic [63:0] fetch_pc;
  if_reason_e  fetch_reason;

  // Responses of stale fetches are dropped
  assign resp_keep = icache_d2h_i.resp_valid && !stale_q && !redirect_i.valid;
  assign buf_taken = buf_valid_q && fetch_ready_i;

  // One fetch in flight, and only if the buffer will have room
  assign issue = !outstanding_q && (!buf_valid_q || buf_taken || redirect_i.valid);

  assign fetch_pc     = redirect_i.valid ? redirect_i.pc : pc_q;
  assign fetch_reason = redirect_i.valid ? redirect_i.reason : reason_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pc_q          <= ResetPc;
      reason_q      <= IF_RESET;
      outstanding_q <= 1'b0;
      stale_q       <= 1'b0;
      req_valid_q   <= 1'b0;
      buf_valid_q   <= 1'b0;
    end
    else
    begin
      req_valid_q <= issue;

      if (icache_d2h_i.resp_valid)
      begin
        outstanding_q <= 1'b0;
        stale_q       <= 1'b0;
      end
      else if (redirect_i.valid && outstanding_q)
      begin
        stale_q <= 1'b1;
      end

      if (issue)
      begin
        pc_q          <= fetch_pc + 64'd4;
        reason_q      <= IF_SEQ;
        outstanding_q <= 1'b1;
      end
      else if (redirect_i.valid)
      begin
        // Redirect target waits for the stale response
        pc_q     <= redirect_i.pc;
        reason_q <= redirect_i.reason;
      end

      if (resp_keep)
        buf_valid_q <= 1'b1;
      else if (buf_taken || redirect_i.valid)
        buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      req_pc_q     <= fetch_pc;
      req_reason_q <= fetch_reason;
    end
    if (resp_keep)
    begin
      buf_pc_q    <= req_pc_q;
      buf_instr_q <= icache_d2h_i.resp_instr;
    end
  end

  assign icache_h2d_o.req_valid  = req_valid_q;
  assign icache_h2d_o.req_pc     = req_pc_q;
  assign icache_h2d_o.req_reason = req_reason_q;

  assign fetch_o.valid = buf_valid_q;
  assign fetch_o.pc    = buf_pc_q;
  assign fetch_o.instr = buf_instr_q;

endmodule

//--- logic/core_backend.sv
// ####################################################################
// Core backend: decode, ALU, branch resolution, data cache access
// and register writeback with the retire trace
// ####################################################################

`timescale 1ns/1ps

module core_backend #(
  parameter logic [63:0] TrapVec = 64'h0
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  core_pkg::fetch_t       fetch_i,
  output logic                   fetch_ready_o,
  output core_pkg::redirect_t    redirect_o,
  output logic [4:0]             rf_raddr_a_o,
  output logic [4:0]             rf_raddr_b_o,
  input  logic [63:0]            rf_rdata_a_i,
  input  logic [63:0]            rf_rdata_b_i,
  output logic                   rf_we_o,
  output logic [4:0]             rf_waddr_o,
  output logic [63:0]            rf_wdata_o,
  output core_pkg::dcache_h2d_t  dcache_h2d_o,
  input  core_pkg::dcache_d2h_t  dcache_d2h_i,
  output core_pkg::instr_trace_t trace_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM_REQ,
    ST_LOAD_WAIT,
    ST_RETIRE
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic        accept;

  logic [31:0] instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_j;

  logic        dec_legal;
  logic        dec_load;
  logic        dec_store;
  logic        dec_wb;
  logic        dec_jump;
  logic [63:0] dec_result;
  logic [63:0] dec_target;

  logic [63:0] pc_q;
  logic [31:0] instr_q;
  logic        legal_q;
  logic        store_q;
  logic        wb_q;
  logic        jump_q;
  logic [63:0] result_q;
  logic [63:0] target_q;
  logic [63:0] addr_q;
  logic [63:0] sdata_q;
  logic [4:0]  rd_q;
  logic [63:0] wb_data;

  assign instr  = fetch_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Operands read straight from the buffered instruction
  assign rf_raddr_a_o = instr[19:15];
  assign rf_raddr_b_o = instr[24:20];

  always_comb
  begin
    dec_legal  = 1'b0;
    dec_load   = 1'b0;
    dec_store  = 1'b0;
    dec_wb     = 1'b0;
    dec_jump   = 1'b0;
    dec_result = '0;
    dec_target = fetch_i.pc + imm_b;
    case (opcode)
      OPC_OP_IMM:
        if (funct3 == F3_ADD)
        begin
          dec_legal  = 1'b1;
          dec_wb     = 1'b1;
          dec_result = rf_rdata_a_i + imm_i;
        end
      OPC_OP:
        if (funct3 == F3_ADD && (funct7 == F7_ADD || funct7 == F7_SUB))
        begin
          dec_legal  = 1'b1;
          dec_wb     = 1'b1;
          dec_result = (funct7 == F7_SUB) ? rf_rdata_a_i - rf_rdata_b_i
                                          : rf_rdata_a_i + rf_rdata_b_i;
        end
      OPC_LOAD:
        if (funct3 == F3_DW)
        begin
          dec_legal = 1'b1;
          dec_load  = 1'b1;
          dec_wb    = 1'b1;
        end
      OPC_STORE:
        if (funct3 == F3_DW)
        begin
          dec_legal = 1'b1;
          dec_store = 1'b1;
        end
      OPC_BRANCH:
        if (funct3 == F3_BEQ || funct3 == F3_BNE)
        begin
          dec_legal = 1'b1;
          dec_jump  = (rf_rdata_a_i == rf_rdata_b_i) ^ (funct3 == F3_BNE);
        end
      OPC_JAL:
      begin
        dec_legal  = 1'b1;
        dec_wb     = 1'b1;
        dec_jump   = 1'b1;
        dec_result = fetch_i.pc + 64'd4;
        dec_target = fetch_i.pc + imm_j;
      end
      default:
      begin
      end
    endcase
  end

  // One instruction at a time, taken only when idle
  assign fetch_ready_o = (state_q == ST_IDLE);
  assign accept        = fetch_ready_o && fetch_i.valid;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (fetch_i.valid)
          state_d = (dec_load || dec_store) ? ST_MEM_REQ : ST_RETIRE;
      ST_MEM_REQ:
        if (dcache_d2h_i.req_ready)
          state_d = store_q ? ST_RETIRE : ST_LOAD_WAIT;
      ST_LOAD_WAIT:
        if (dcache_d2h_i.resp_valid)
          state_d = ST_RETIRE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      pc_q     <= fetch_i.pc;
      instr_q  <= instr;
      rd_q     <= instr[11:7];
      legal_q  <= dec_legal;
      store_q  <= dec_store;
      wb_q     <= dec_wb;
      jump_q   <= dec_jump;
      result_q <= dec_result;
      target_q <= dec_target;
      addr_q   <= rf_rdata_a_i + (dec_store ? imm_s : imm_i);
      sdata_q  <= rf_rdata_b_i;
    end
    else if (state_q == ST_LOAD_WAIT && dcache_d2h_i.resp_valid)
    begin
      result_q <= dcache_d2h_i.resp_value;
    end
  end

  // Request held until the cache takes it
  assign dcache_h2d_o.req_valid   = (state_q == ST_MEM_REQ);
  assign dcache_h2d_o.req_address = addr_q;
  assign dcache_h2d_o.req_value   = sdata_q;
  assign dcache_h2d_o.req_op      = store_q ? MEM_STORE : MEM_LOAD;

  // x0 always reads back as zero
  assign wb_data = (rd_q == 5'd0) ? 64'd0 : result_q;

  assign rf_we_o    = (state_q == ST_RETIRE) && wb_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = wb_data;

  // Leave the sequential path on taken branches, JAL and traps
  assign redirect_o.valid  = (state_q == ST_RETIRE) && (jump_q || !legal_q);
  assign redirect_o.pc     = legal_q ? target_q : TrapVec;
  assign redirect_o.reason = legal_q ? IF_BRANCH : IF_TRAP;

  assign trace_o.valid       = (state_q == ST_RETIRE);
  assign trace_o.pc          = pc_q;
  assign trace_o.instr_word  = instr_q;
  assign trace_o.gpr_written = wb_q;
  assign trace_o.gpr         = rd_q;
  assign trace_o.gpr_data    = wb_data;
  assign trace_o.illegal     = !legal_q;
  assign trace_o.reserved    = 32'd0;

endmodule

//--- logic/core_pipeline.sv
// ####################################################################
// Core pipeline: frontend, backend and register file joined together
// ####################################################################

`timescale 1ns/1ps

module core_pipeline #(
  parameter logic [63:0] ResetPc = 64'h0,
  parameter logic [63:0] TrapVec = 64'h0
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  output core_pkg::icache_h2d_t  icache_h2d_o,
  input  core_pkg::icache_d2h_t  icache_d2h_i,
  output core_pkg::dcache_h2d_t  dcache_h2d_o,
  input  core_pkg::dcache_d2h_t  dcache_d2h_i,
  output core_pkg::instr_trace_t dbg_o
);
  import core_pkg::*;

  fetch_t      fetch;
  logic        fetch_ready;
  redirect_t   redirect;
  logic [4:0]  rf_raddr_a;
  logic [4:0]  rf_raddr_b;
  logic [63:0] rf_rdata_a;
  logic [63:0] rf_rdata_b;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [63:0] rf_wdata;

  core_frontend #(
    .ResetPc (ResetPc)
  ) frontend (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .icache_h2d_o  (icache_h2d_o),
    .icache_d2h_i  (icache_d2h_i),
    .redirect_i    (redirect),
    .fetch_o       (fetch),
    .fetch_ready_i (fetch_ready)
  );

  core_backend #(
    .TrapVec (TrapVec)
  ) backend (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .fetch_i       (fetch),
    .fetch_ready_o (fetch_ready),
    .redirect_o    (redirect),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .dcache_h2d_o  (dcache_h2d_o),
    .dcache_d2h_i  (dcache_d2h_i),
    .trace_o       (dbg_o)
  );

  core_regfile regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

endmodule

//--- logic/pipeline_wrapper.sv
// ####################################################################
// Top level around the core pipeline, flattening the packed struct
// cache and trace ports into plain signals for the harness
// ####################################################################

`timescale 1ns/1ps

module pipeline_wrapper #(
  parameter logic [63:0] ResetPc = 64'h0000_0000_8000_0000,
  parameter logic [63:0] TrapVec = 64'h0000_0000_8000_0100
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  // Instruction cache
  output logic                 icache_req_valid_o,
  output logic [63:0]          icache_req_pc_o,
  output core_pkg::if_reason_e icache_req_reason_o,
  input  logic                 icache_resp_valid_i,
  input  logic [31:0]          icache_resp_instr_i,

  // Data cache
  output logic                 dcache_req_valid_o,
  output logic [63:0]          dcache_req_address_o,
  output logic [63:0]          dcache_req_value_o,
  output core_pkg::mem_op_e    dcache_req_op_o,
  input  logic                 dcache_req_ready_i,
  input  logic                 dcache_resp_valid_i,
  input  logic [63:0]          dcache_resp_value_i,

  // Retire trace
  output logic                 dbg_valid_o,
  output logic [63:0]          dbg_pc_o,
  output logic [31:0]          dbg_instr_word_o,
  output logic                 dbg_gpr_written_o,
  output logic [4:0]           dbg_gpr_o,
  output logic [63:0]          dbg_gpr_data_o,
  output logic                 dbg_illegal_o
);
  import core_pkg::*;

  icache_h2d_t  icache_h2d;
  icache_d2h_t  icache_d2h;
  dcache_h2d_t  dcache_h2d;
  dcache_d2h_t  dcache_d2h;
  instr_trace_t dbg;

  core_pipeline #(
    .ResetPc (ResetPc),
    .TrapVec (TrapVec)
  ) pipeline (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .icache_h2d_o (icache_h2d),
    .icache_d2h_i (icache_d2h),
    .dcache_h2d_o (dcache_h2d),
    .dcache_d2h_i (dcache_d2h),
    .dbg_o        (dbg)
  );

  // Instruction cache
  assign icache_req_valid_o    = icache_h2d.req_valid;
  assign icache_req_pc_o       = icache_h2d.req_pc;
  assign icache_req_reason_o   = icache_h2d.req_reason;
  assign icache_d2h.resp_valid = icache_resp_valid_i;
  assign icache_d2h.resp_instr = icache_resp_instr_i;

  // Data cache
  assign dcache_req_valid_o    = dcache_h2d.req_valid;
  assign dcache_req_address_o  = dcache_h2d.req_address;
  assign dcache_req_value_o    = dcache_h2d.req_value;
  assign dcache_req_op_o       = dcache_h2d.req_op;
  assign dcache_d2h.req_ready  = dcache_req_ready_i;
  assign dcache_d2h.resp_valid = dcache_resp_valid_i;
  assign dcache_d2h.resp_value = dcache_resp_value_i;

  // Retire trace
  assign dbg_valid_o       = dbg.valid;
  assign dbg_pc_o          = dbg.pc;
  assign dbg_instr_word_o  = dbg.instr_word;
  assign dbg_gpr_written_o = dbg.gpr_written;
  assign dbg_gpr_o         = dbg.gpr;
  assign dbg_gpr_data_o    = dbg.gpr_data;
  assign dbg_illegal_o     = dbg.illegal;

endmodule

//--- bench/tb_pipeline.sv
// ####################################################################
// Testbench for the RV64 core wrapper: memory models, ISA reference
// model and a retire trace checker
// ####################################################################

`timescale 1ns/1ps

module tb_pipeline;
  import core_pkg::*;

  localparam logic [63:0] RESET_PC   = 64'h0000_0000_8000_0000;
  localparam logic [63:0] TRAP_VEC   = 64'h0000_0000_8000_0100;
  localparam int          NUM_RETIRE = 14;
  localparam int          CLK_PERIOD = 20;
  localparam int          RST_CYCLES = 10;

  logic        clk;
  logic        arst_n;
  logic        ic_resp_valid;
  logic [31:0] ic_resp_instr;
  logic        dc_ready;
  logic        dc_resp_valid;
  logic [63:0] dc_resp_value;

  logic        ic_req_valid;
  logic [63:0] ic_req_pc;
  if_reason_e  ic_req_reason;
  logic        dc_req_valid;
  logic [63:0] dc_req_address;
  logic [63:0] dc_req_value;
  mem_op_e     dc_req_op;
  logic        dbg_valid;
  logic [63:0] dbg_pc;
  logic [31:0] dbg_instr_word;
  logic        dbg_gpr_written;
  logic [4:0]  dbg_gpr;
  logic [63:0] dbg_gpr_data;
  logic        dbg_illegal;

  // Program image used by both the fetch model and the reference model
  logic [31:0] imem [logic [63:0]];
  logic [63:0] dmem [logic [63:0]];
  logic [63:0] st_addr_q [$];
  logic [63:0] st_val_q [$];

  // Every instruction fetch request in issue order
  logic [63:0] fetch_pc_q [$];
  if_reason_e  fetch_rsn_q [$];

  // Architectural state of the reference model
  logic [63:0] ref_pc;
  logic [63:0] ref_x [32];
  logic [63:0] ref_mem [logic [63:0]];
  logic        exp_store;
  logic [63:0] exp_st_addr;
  logic [63:0] exp_st_val;
  if_reason_e  exp_reason;

  int errors;
  int test_errors_base;
  int tests_passed;
  int tests_failed;
  int retired;

  pipeline_wrapper #(
    .ResetPc (RESET_PC),
    .TrapVec (TRAP_VEC)
  ) u_dut (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .icache_req_valid_o   (ic_req_valid),
    .icache_req_pc_o      (ic_req_pc),
    .icache_req_reason_o  (ic_req_reason),
    .icache_resp_valid_i  (ic_resp_valid),
    .icache_resp_instr_i  (ic_resp_instr),
    .dcache_req_valid_o   (dc_req_valid),
    .dcache_req_address_o (dc_req_address),
    .dcache_req_value_o   (dc_req_value),
    .dcache_req_op_o      (dc_req_op),
    .dcache_req_ready_i   (dc_ready),
    .dcache_resp_valid_i  (dc_resp_valid),
    .dcache_resp_value_i  (dc_resp_value),
    .dbg_valid_o          (dbg_valid),
    .dbg_pc_o             (dbg_pc),
    .dbg_instr_word_o     (dbg_instr_word),
    .dbg_gpr_written_o    (dbg_gpr_written),
    .dbg_gpr_o            (dbg_gpr),
    .dbg_gpr_data_o       (dbg_gpr_data),
    .dbg_illegal_o        (dbg_illegal)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Instruction encoders
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Unmapped addresses fetch the illegal all-zero word
  function automatic logic [31:0] fetch_word(logic [63:0] addr);
    if (imem.exists(addr))
      return imem[addr];
    return 32'h0;
  endfunction

  task automatic load_program();
    imem[RESET_PC + 64'h00] = enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);
    imem[RESET_PC + 64'h04] = enc_i(12'hffd, 5'd0, 3'b000, 5'd2, 7'b0010011);
    imem[RESET_PC + 64'h08] = enc_r(7'b0000000, 5'd2, 5'd1, 5'd3);
    imem[RESET_PC + 64'h0c] = enc_r(7'b0100000, 5'd2, 5'd1, 5'd4);
    imem[RESET_PC + 64'h10] = enc_i(12'd7, 5'd1, 3'b000, 5'd0, 7'b0010011);
    imem[RESET_PC + 64'h14] = enc_i(12'h100, 5'd0, 3'b000, 5'd5, 7'b0010011);
    imem[RESET_PC + 64'h18] = enc_s(12'd8, 5'd4, 5'd5);
    imem[RESET_PC + 64'h1c] = enc_i(12'd8, 5'd5, 3'b011, 5'd6, 7'b0000011);
    imem[RESET_PC + 64'h20] = enc_b(13'd8, 5'd4, 5'd6, 3'b000);
    // Wrong path behind the taken BEQ
    imem[RESET_PC + 64'h24] = enc_i(12'd1, 5'd0, 3'b000, 5'd7, 7'b0010011);
    imem[RESET_PC + 64'h28] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
    imem[RESET_PC + 64'h2c] = enc_j(21'd8, 5'd8);
    imem[RESET_PC + 64'h30] = enc_i(12'd2, 5'd0, 3'b000, 5'd7, 7'b0010011);
    imem[RESET_PC + 64'h34] = 32'hffff_ffff;
    imem[TRAP_VEC + 64'h00] = enc_i(12'd9, 5'd0, 3'b000, 5'd9, 7'b0010011);
    imem[TRAP_VEC + 64'h04] = enc_j(21'd0, 5'd0);
  endtask

  // Steps the ISA model by one instruction and returns the expected trace
  function automatic instr_trace_t ref_step();
    instr_trace_t t;
    logic [31:0]  ins;
    logic [63:0]  a;
    logic [63:0]  b;
    logic [63:0]  nxt;
    logic [63:0]  val;
    logic         wr;
    logic         jump;
    logic [63:0]  off_i;
    logic [63:0]  off_s;
    logic [63:0]  off_b;
    logic [63:0]  off_j;
    ins = fetch_word(ref_pc);
    a   = ref_x[ins[19:15]];
    b   = ref_x[ins[24:20]];
    nxt = ref_pc + 64'd4;
    val = 64'd0;
    wr  = 1'b0;
    jump = 1'b0;
    t   = '0;
    // Immediates placed at the top and sign extended by arithmetic shifts
    off_i = $signed({ins[31:20], 52'd0}) >>> 52;
    off_s = $signed({ins[31:25], ins[11:7], 52'd0}) >>> 52;
    off_b = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 52'd0}) >>> 51;
    off_j = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 44'd0}) >>> 43;
    exp_store       = 1'b0;
    t.valid         = 1'b1;
    t.pc            = ref_pc;
    t.instr_word    = ins;
    t.gpr           = ins[11:7];
    t.illegal       = 1'b1;
    if (ins[6:0] == 7'h13 && ins[14:12] == 3'd0)
    begin
      t.illegal = 1'b0;
      wr        = 1'b1;
      val       = a + off_i;
    end
    else if (ins[6:0] == 7'h33 && ins[14:12] == 3'd0 && ins[31:25] == 7'h00)
    begin
      t.illegal = 1'b0;
      wr        = 1'b1;
      val       = a + b;
    end
    else if (ins[6:0] == 7'h33 && ins[14:12] == 3'd0 && ins[31:25] == 7'h20)
    begin
      t.illegal = 1'b0;
      wr        = 1'b1;
      val       = a - b;
    end
    else if (ins[6:0] == 7'h03 && ins[14:12] == 3'd3)
    begin
      t.illegal = 1'b0;
      wr        = 1'b1;
      val       = a + off_i;
      val       = ref_mem.exists(val) ? ref_mem[val] : 64'd0;
    end
    else if (ins[6:0] == 7'h23 && ins[14:12] == 3'd3)
    begin
      t.illegal   = 1'b0;
      exp_store   = 1'b1;
      exp_st_addr = a + off_s;
      exp_st_val  = b;
      ref_mem[exp_st_addr] = b;
    end
    else if (ins[6:0] == 7'h63 && (ins[14:12] == 3'd0 || ins[14:12] == 3'd1))
    begin
      t.illegal = 1'b0;
      if ((a == b) == (ins[14:12] == 3'd0))
      begin
        jump = 1'b1;
        nxt  = ref_pc + off_b;
      end
    end
    else if (ins[6:0] == 7'h6f)
    begin
      t.illegal = 1'b0;
      wr        = 1'b1;
      jump      = 1'b1;
      val       = ref_pc + 64'd4;
      nxt       = ref_pc + off_j;
    end
    // Cause of the fetch that brings in the next instruction
    if (t.illegal)
    begin
      nxt        = TRAP_VEC;
      exp_reason = IF_TRAP;
    end
    else
    begin
      exp_reason = jump ? IF_BRANCH : IF_SEQ;
    end
    if (wr && ins[11:7] != 5'd0)
      ref_x[ins[11:7]] = val;
    t.gpr_written = wr;
    t.gpr_data    = (ins[11:7] == 5'd0) ? 64'd0 : val;
    ref_pc        = nxt;
    return t;
  endfunction

  task automatic check(string what, logic [63:0] got, logic [63:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Pairs a retired pc with its fetch request, skipping wrong-path fetches
  task automatic check_fetch_reason(logic [63:0] pc, if_reason_e rsn);
    while (fetch_pc_q.size() != 0 && fetch_pc_q[0] != pc)
    begin
      void'(fetch_pc_q.pop_front());
      void'(fetch_rsn_q.pop_front());
    end
    if (fetch_pc_q.size() == 0)
    begin
      $display("No fetch request was seen for retired pc %h", pc);
      errors++;
    end
    else
    begin
      void'(fetch_pc_q.pop_front());
      check("fetch reason", 64'(fetch_rsn_q.pop_front()), 64'(rsn));
    end
  endtask

  task automatic report_test(string name);
    if (errors == test_errors_base)
    begin
      $display("Test %s: passed", name);
      tests_passed++;
    end
    else
    begin
      $display("Test %s: failed with %0d errors", name, errors - test_errors_base);
      tests_failed++;
    end
    test_errors_base = errors;
  endtask

  // Instruction cache model answering each request after 1 to 4 cycles
  initial
  begin
    int          lat;
    logic [63:0] pc;
    forever
    begin
      @(posedge clk);
      if (arst_n && ic_req_valid)
      begin
        pc  = ic_req_pc;
        fetch_pc_q.push_back(ic_req_pc);
        fetch_rsn_q.push_back(ic_req_reason);
        lat = int'($urandom_range(1, 4));
        repeat (lat - 1) @(posedge clk);
        #1;
        ic_resp_valid = 1'b1;
        ic_resp_instr = fetch_word(pc);
        @(posedge clk);
        #1;
        ic_resp_valid = 1'b0;
      end
    end
  end

  // Data cache model with random ready and load latency of 1 to 3 cycles
  initial
  begin
    int          pend_cnt;
    logic [63:0] pend_val;
    logic        resp_now;
    pend_cnt = 0;
    pend_val = 64'd0;
    forever
    begin
      @(posedge clk);
      resp_now = 1'b0;
      if (pend_cnt > 0)
      begin
        pend_cnt--;
        resp_now = (pend_cnt == 0);
      end
      if (arst_n && dc_req_valid && dc_ready)
      begin
        if (dc_req_op == MEM_STORE)
        begin
          dmem[dc_req_address] = dc_req_value;
          st_addr_q.push_back(dc_req_address);
          st_val_q.push_back(dc_req_value);
        end
        else
        begin
          pend_cnt = int'($urandom_range(1, 3));
          pend_val = dmem.exists(dc_req_address) ? dmem[dc_req_address] : 64'd0;
        end
      end
      #1;
      dc_resp_valid = resp_now;
      dc_resp_value = pend_val;
      dc_ready      = ($urandom_range(0, 99) < 55);
    end
  end

  // Compares every retirement with the reference model
  initial
  begin
    instr_trace_t exp;
    if_reason_e   rsn;
    forever
    begin
      @(posedge clk);
      if (arst_n && dbg_valid && retired < NUM_RETIRE)
      begin
        rsn = exp_reason;
        exp = ref_step();
        check("retire pc", dbg_pc, exp.pc);
        check("instr word", 64'(dbg_instr_word), 64'(exp.instr_word));
        check("illegal flag", 64'(dbg_illegal), 64'(exp.illegal));
        check("gpr written", 64'(dbg_gpr_written), 64'(exp.gpr_written));
        check_fetch_reason(exp.pc, rsn);
        if (exp.gpr_written)
        begin
          check("gpr index", 64'(dbg_gpr), 64'(exp.gpr));
          check("gpr data", dbg_gpr_data, exp.gpr_data);
        end
        if (exp_store)
        begin
          if (st_addr_q.size() == 0)
          begin
            $display("Store at pc %h never reached the data port", exp.pc);
            errors++;
          end
          else
          begin
            check("store address", st_addr_q.pop_front(), exp_st_addr);
            check("store value", st_val_q.pop_front(), exp_st_val);
          end
        end
        retired++;
        case (retired)
          1:       report_test("reset");
          6:       report_test("alu");
          8:       report_test("load store");
          11:      report_test("control flow");
          14:      report_test("illegal trap");
          default: ;
        endcase
      end
    end
  end

  // Watchdog sized from the number of expected retirements
  initial
  begin
    #((RST_CYCLES + NUM_RETIRE * 200) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d instructions retired", retired, NUM_RETIRE);
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    void'($urandom(32'hb2dbeaf1));
    clk              = 1'b0;
    arst_n           = 1'b0;
    ic_resp_valid    = 1'b0;
    ic_resp_instr    = 32'h0;
    dc_ready         = 1'b0;
    dc_resp_valid    = 1'b0;
    dc_resp_value    = 64'd0;
    errors           = 0;
    test_errors_base = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    retired          = 0;
    ref_pc           = RESET_PC;
    exp_reason       = IF_RESET;
    for (int i = 0; i < 32; i++)
      ref_x[i] = 64'd0;
    load_program();

    repeat (RST_CYCLES)
    begin
      @(posedge clk);
      check("icache req valid in reset", 64'(ic_req_valid), 64'd0);
      check("dcache req valid in reset", 64'(dc_req_valid), 64'd0);
      check("trace valid in reset", 64'(dbg_valid), 64'd0);
    end
    #1;
    arst_n = 1'b1;

    wait (retired == NUM_RETIRE);
    @(posedge clk);
    if (st_addr_q.size() != 0)
    begin
      $display("Data port saw %0d stores more than were retired", st_addr_q.size());
      errors++;
    end
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- core.f
logic/core_pkg.sv
logic/core_regfile.sv
logic/core_frontend.sv
logic/core_backend.sv
logic/core_pipeline.sv
logic/pipeline_wrapper.sv
bench/tb_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f core.f --top-module tb_pipeline -o tb_pipeline
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_pipeline > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
fi
exit 1
